// File: Makefile
VERILATOR ?= verilator
TOP ?= cpu_tb
BUILD ?= obj_dir
LOG ?= sim.log
FILELIST ?= tb.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Test failures found" $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
	input logic clk,
	input logic rst_n,
	input logic fetch_done,
	input logic mem_done,
	input logic is_halt,
	input logic branch_taken,
	input logic [cpu_pkg::data_width-1:0] branch_target,
	output logic start_fetch,
	output logic start_decode,
	output logic start_exec,
	output logic start_mem,
	output logic start_wb,
	output logic halted,
	output logic [cpu_pkg::data_width-1:0] pc,
	output logic [cpu_pkg::data_width-1:0] pc_plus_4
);

	logic [cpu_pkg::phase_width-1:0] phase;
	logic [cpu_pkg::phase_width-1:0] phase_next;

	assign start_fetch = phase == cpu_pkg::ph_fetch;
	assign start_decode = phase == cpu_pkg::ph_decode;
	assign start_exec = phase == cpu_pkg::ph_exec;
	assign start_mem = phase == cpu_pkg::ph_mem;
	assign start_wb = phase == cpu_pkg::ph_wb;
	assign halted = phase == cpu_pkg::ph_halt;
	assign pc_plus_4 = pc + 32'd4;

	always_comb begin
		phase_next = phase;
		case (phase)
			cpu_pkg::ph_fetch: phase_next = cpu_pkg::ph_fetch_wait;
			cpu_pkg::ph_fetch_wait: if (fetch_done) phase_next = cpu_pkg::ph_decode;
			cpu_pkg::ph_decode: phase_next = cpu_pkg::ph_exec;
			cpu_pkg::ph_exec: phase_next = is_halt ? cpu_pkg::ph_halt : cpu_pkg::ph_mem;
			cpu_pkg::ph_mem,
			cpu_pkg::ph_mem_wait: phase_next = mem_done ? cpu_pkg::ph_wb : cpu_pkg::ph_mem_wait;
			cpu_pkg::ph_wb: phase_next = cpu_pkg::ph_fetch;
			default: phase_next = cpu_pkg::ph_halt; // stays here until reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= cpu_pkg::ph_fetch;
			pc <= cpu_pkg::reset_pc;
		end else begin
			phase <= phase_next;
			if (start_wb)
				pc <= branch_taken ? branch_target : pc_plus_4;
		end
	end

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
	input logic clk,
	input logic rst_n,
	output logic ibus_cyc,
	output logic ibus_stb,
	output logic [cpu_pkg::data_width-1:0] ibus_adr,
	input logic [cpu_pkg::data_width-1:0] ibus_dat_r,
	input logic ibus_ack,
	output logic dbus_cyc,
	output logic dbus_stb,
	output logic dbus_we,
	output logic [cpu_pkg::data_width-1:0] dbus_adr,
	output logic [cpu_pkg::data_width-1:0] dbus_dat_w,
	input logic [cpu_pkg::data_width-1:0] dbus_dat_r,
	input logic dbus_ack,
	output logic halted
);

	logic start_fetch;
	logic start_decode;
	logic start_exec;
	logic start_mem;
	logic start_wb;
	logic fetch_done;
	logic mem_done;
	logic [cpu_pkg::data_width-1:0] pc;
	logic [cpu_pkg::data_width-1:0] pc_plus_4;
	cpu_pkg::instr_word_t instr;

	logic [cpu_pkg::reg_addr_width-1:0] ra_sel;
	logic [cpu_pkg::reg_addr_width-1:0] rb_sel;
	logic [cpu_pkg::reg_addr_width-1:0] rd_sel;
	logic [cpu_pkg::data_width-1:0] imm32;
	cpu_pkg::alu_op_t alu_opc;
	logic alu_op1_ra;
	logic alu_op2_rb;
	logic mem_load;
	logic mem_store;
	logic branch_ra;
	cpu_pkg::branch_cond_t branch_condition;
	cpu_pkg::instr_class_t instr_class;
	logic is_call;
	logic update_rd;
	logic is_halt;

	logic [cpu_pkg::data_width-1:0] ra_val;
	logic [cpu_pkg::data_width-1:0] rb_val;
	logic branch_taken;
	logic [cpu_pkg::data_width-1:0] alu_out;
	logic mem_load_out;
	logic mem_store_out;
	logic [cpu_pkg::data_width-1:0] store_val;
	logic [cpu_pkg::data_width-1:0] wr_val;
	logic wr_result;
	logic [cpu_pkg::reg_addr_width-1:0] rd_sel_out;
	logic [cpu_pkg::data_width-1:0] result;
	logic rf_wr_en;

	assign rf_wr_en = wr_result && start_wb; // register write lands on the write-back edge

	cpu_control u_control (
		.clk(clk), .rst_n(rst_n), .fetch_done(fetch_done), .mem_done(mem_done),
		.is_halt(is_halt), .branch_taken(branch_taken), .branch_target(alu_out),
		.start_fetch(start_fetch), .start_decode(start_decode), .start_exec(start_exec),
		.start_mem(start_mem), .start_wb(start_wb), .halted(halted),
		.pc(pc), .pc_plus_4(pc_plus_4)
	);

	cpu_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .start_fetch(start_fetch), .pc(pc),
		.ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack), .ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb), .ibus_adr(ibus_adr), .fetch_done(fetch_done), .instr(instr)
	);

	cpu_decode u_decode (
		.clk(clk), .rst_n(rst_n), .start_decode(start_decode), .instr(instr),
		.ra_sel(ra_sel), .rb_sel(rb_sel), .rd_sel(rd_sel), .imm32(imm32),
		.alu_opc(alu_opc), .alu_op1_ra(alu_op1_ra), .alu_op2_rb(alu_op2_rb),
		.mem_load(mem_load), .mem_store(mem_store), .branch_ra(branch_ra),
		.branch_condition(branch_condition), .instr_class(instr_class),
		.is_call(is_call), .update_rd(update_rd), .is_halt(is_halt)
	);

	cpu_regfile u_regfile (
		.clk(clk), .ra_sel(ra_sel), .rb_sel(rb_sel), .wr_en(rf_wr_en),
		.wr_sel(rd_sel_out), .wr_data(result), .ra(ra_val), .rb(rb_val)
	);

	cpu_exec u_exec (
		.clk(clk), .rst_n(rst_n), .start_exec(start_exec), .ra(ra_val), .rb(rb_val),
		.imm32(imm32), .pc_plus_4(pc_plus_4), .rd_sel(rd_sel), .update_rd(update_rd),
		.alu_opc(alu_opc), .alu_op1_ra(alu_op1_ra), .alu_op2_rb(alu_op2_rb),
		.mem_load(mem_load), .mem_store(mem_store), .branch_ra(branch_ra),
		.branch_condition(branch_condition), .instr_class(instr_class), .is_call(is_call),
		.branch_taken(branch_taken), .alu_out(alu_out), .mem_load_out(mem_load_out),
		.mem_store_out(mem_store_out), .store_val(store_val), .wr_val(wr_val),
		.wr_result(wr_result), .rd_sel_out(rd_sel_out)
	);

	cpu_mem u_mem (
		.clk(clk), .rst_n(rst_n), .start_mem(start_mem), .mem_load(mem_load_out),
		.mem_store(mem_store_out), .alu_out(alu_out), .store_val(store_val),
		.wr_val(wr_val), .dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
		.dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we), .dbus_adr(dbus_adr),
		.dbus_dat_w(dbus_dat_w), .mem_done(mem_done), .result(result)
	);

endmodule

`default_nettype wire

// File: hw/cpu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_decode (
	input logic clk,
	input logic rst_n,
	input logic start_decode,
	input cpu_pkg::instr_word_t instr,
	output logic [cpu_pkg::reg_addr_width-1:0] ra_sel,
	output logic [cpu_pkg::reg_addr_width-1:0] rb_sel,
	output logic [cpu_pkg::reg_addr_width-1:0] rd_sel,
	output logic [cpu_pkg::data_width-1:0] imm32,
	output cpu_pkg::alu_op_t alu_opc,
	output logic alu_op1_ra,
	output logic alu_op2_rb,
	output logic mem_load,
	output logic mem_store,
	output logic branch_ra,
	output cpu_pkg::branch_cond_t branch_condition,
	output cpu_pkg::instr_class_t instr_class,
	output logic is_call,
	output logic update_rd,
	output logic is_halt
);

	cpu_pkg::instr_class_t cls;
	logic is_branch;
	logic is_mem;

	assign cls = instr.arith.instr_class; // class bits sit in the same place in both formats
	assign is_branch = cls == cpu_pkg::class_branch;
	assign is_mem = cls == cpu_pkg::class_mem;

	// ------------------------------------------------------------------
	// control outputs
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_class <= cpu_pkg::class_misc;
			branch_condition <= cpu_pkg::cond_never;
			branch_ra <= 1'b0;
			is_call <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			update_rd <= 1'b0;
			is_halt <= 1'b0;
		end else if (start_decode) begin
			instr_class <= cls;
			branch_condition <= is_branch ? instr.branch.cond : cpu_pkg::cond_never;
			branch_ra <= is_branch && instr.branch.via_reg;
			is_call <= is_branch && instr.branch.is_call;
			mem_load <= is_mem && instr.arith.opcode == cpu_pkg::mem_op_load;
			mem_store <= is_mem && instr.arith.opcode == cpu_pkg::mem_op_store;
			is_halt <= cls == cpu_pkg::class_misc && instr.arith.opcode == cpu_pkg::misc_op_halt;
			case (cls)
				cpu_pkg::class_arith: update_rd <= 1'b1;
				cpu_pkg::class_branch: update_rd <= instr.branch.is_call; // link write
				cpu_pkg::class_mem: update_rd <= instr.arith.opcode == cpu_pkg::mem_op_load;
				default: update_rd <= 1'b0;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// selects, immediate and ALU operands
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (start_decode) begin
			rb_sel <= instr.arith.rb;
			if (is_branch) begin
				ra_sel <= instr.branch.ra;
				rd_sel <= instr.branch.rd;
				imm32 <= {{15{instr.branch.imm16[16]}}, instr.branch.imm16};
				alu_opc <= cpu_pkg::alu_add; // pc_plus_4 + offset
				alu_op1_ra <= 1'b0;
				alu_op2_rb <= 1'b0;
			end else begin
				ra_sel <= instr.arith.ra;
				rd_sel <= instr.arith.rd;
				if (instr.arith.opcode == cpu_pkg::alu_movhi && !is_mem)
					imm32 <= {16'h0000, instr.arith.use_pc, instr.arith.imm16};
				else
					imm32 <= {{17{instr.arith.imm16[14]}}, instr.arith.imm16};
				if (is_mem) begin
					alu_opc <= cpu_pkg::alu_add; // address is ra + imm
					alu_op1_ra <= 1'b1;
					alu_op2_rb <= 1'b0;
				end else begin
					alu_opc <= cpu_pkg::alu_op_t'(instr.arith.opcode);
					alu_op1_ra <= !instr.arith.use_pc;
					alu_op2_rb <= !instr.arith.use_imm;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/cpu_exec.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_exec (
	input logic clk,
	input logic rst_n,
	input logic start_exec,
	input logic [cpu_pkg::data_width-1:0] ra,
	input logic [cpu_pkg::data_width-1:0] rb,
	input logic [cpu_pkg::data_width-1:0] imm32,
	input logic [cpu_pkg::data_width-1:0] pc_plus_4,
	input logic [cpu_pkg::reg_addr_width-1:0] rd_sel,
	input logic update_rd,
	input cpu_pkg::alu_op_t alu_opc,
	input logic alu_op1_ra,
	input logic alu_op2_rb,
	input logic mem_load,
	input logic mem_store,
	input logic branch_ra,
	input cpu_pkg::branch_cond_t branch_condition,
	input cpu_pkg::instr_class_t instr_class,
	input logic is_call,
	output logic branch_taken,
	output logic [cpu_pkg::data_width-1:0] alu_out,
	output logic mem_load_out,
	output logic mem_store_out,
	output logic [cpu_pkg::data_width-1:0] store_val,
	output logic [cpu_pkg::data_width-1:0] wr_val,
	output logic wr_result,
	output logic [cpu_pkg::reg_addr_width-1:0] rd_sel_out
);

	localparam int w = cpu_pkg::data_width;

	logic [w-1:0] op1;
	logic [w-1:0] op2;
	logic [w-1:0] alu_q;
	logic alu_c;
	logic alu_z;
	logic cond_met;
	logic c_flag; // status flags are hidden from software
	logic z_flag;

	assign op1 = alu_op1_ra ? ra : pc_plus_4;
	assign op2 = alu_op2_rb ? rb : imm32;
	assign alu_z = op1 == op2;

	// ------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------
	always_comb begin
		alu_c = 1'b0;
		alu_q = '0;
		case (alu_opc)
			cpu_pkg::alu_add: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
			cpu_pkg::alu_addc: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {{w{1'b0}}, c_flag};
			cpu_pkg::alu_sub: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
			cpu_pkg::alu_subc: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {{w{1'b0}}, c_flag};
			cpu_pkg::alu_lsl: {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
			cpu_pkg::alu_lsr: alu_q = op1 >> op2[4:0];
			cpu_pkg::alu_and: alu_q = op1 & op2;
			cpu_pkg::alu_xor: alu_q = op1 ^ op2;
			cpu_pkg::alu_bic: alu_q = op1 & ~(32'h1 << op2[4:0]);
			cpu_pkg::alu_bst: alu_q = op1 | (32'h1 << op2[4:0]);
			cpu_pkg::alu_or: alu_q = op1 | op2;
			cpu_pkg::alu_movhi: alu_q = {imm32[15:0], 16'h0000};
			cpu_pkg::alu_zero: alu_q = '0;
			cpu_pkg::alu_asr: alu_q = $unsigned($signed(op1) >>> op2[4:0]);
			cpu_pkg::alu_mov: alu_q = op1;
			default: alu_q = '0;
		endcase
	end

	always_comb begin
		case (branch_condition)
			cpu_pkg::cond_always: cond_met = 1'b1;
			cpu_pkg::cond_ne: cond_met = !z_flag;
			cpu_pkg::cond_eq: cond_met = z_flag;
			cpu_pkg::cond_cc: cond_met = !c_flag;
			cpu_pkg::cond_cs: cond_met = c_flag;
			default: cond_met = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------
	// result registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			branch_taken <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			wr_result <= 1'b0;
			z_flag <= 1'b0;
			c_flag <= 1'b0;
		end else if (start_exec) begin
			branch_taken <= instr_class == cpu_pkg::class_branch && cond_met;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			wr_result <= update_rd;
			if (instr_class == cpu_pkg::class_arith) begin
				z_flag <= alu_z;
				c_flag <= alu_c;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_exec) begin
			alu_out <= branch_ra ? ra : alu_q; // also the branch target
			store_val <= rb;
			wr_val <= is_call ? pc_plus_4 : alu_q;
			rd_sel_out <= rd_sel;
		end
	end

endmodule

`default_nettype wire

// File: hw/cpu_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_fetch (
	input logic clk,
	input logic rst_n,
	input logic start_fetch,
	input logic [cpu_pkg::data_width-1:0] pc,
	input logic [cpu_pkg::data_width-1:0] ibus_dat_r,
	input logic ibus_ack,
	output logic ibus_cyc,
	output logic ibus_stb,
	output logic [cpu_pkg::data_width-1:0] ibus_adr,
	output logic fetch_done,
	output cpu_pkg::instr_word_t instr
);

	assign ibus_stb = ibus_cyc; // classic cycle with a single transfer
	assign fetch_done = ibus_cyc && ibus_ack;

	always_ff @(posedge clk) begin
		if (!rst_n)
			ibus_cyc <= 1'b0;
		else if (start_fetch)
			ibus_cyc <= 1'b1;
		else if (fetch_done)
			ibus_cyc <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (start_fetch)
			ibus_adr <= pc; // held steady until ack
		if (fetch_done)
			instr <= cpu_pkg::instr_word_t'(ibus_dat_r);
	end

endmodule

`default_nettype wire

// File: hw/cpu_mem.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_mem (
	input logic clk,
	input logic rst_n,
	input logic start_mem,
	input logic mem_load,
	input logic mem_store,
	input logic [cpu_pkg::data_width-1:0] alu_out,
	input logic [cpu_pkg::data_width-1:0] store_val,
	input logic [cpu_pkg::data_width-1:0] wr_val,
	input logic [cpu_pkg::data_width-1:0] dbus_dat_r,
	input logic dbus_ack,
	output logic dbus_cyc,
	output logic dbus_stb,
	output logic dbus_we,
	output logic [cpu_pkg::data_width-1:0] dbus_adr,
	output logic [cpu_pkg::data_width-1:0] dbus_dat_w,
	output logic mem_done,
	output logic [cpu_pkg::data_width-1:0] result
);

	logic access;
	logic ack_seen;
	logic [cpu_pkg::data_width-1:0] load_q;

	assign access = mem_load || mem_store;
	assign ack_seen = dbus_cyc && dbus_ack;
	assign dbus_stb = dbus_cyc;
	assign mem_done = (start_mem && !access) || ack_seen; // no bus cycle without an access
	assign result = mem_load ? load_q : wr_val;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dbus_cyc <= 1'b0;
			dbus_we <= 1'b0;
		end else if (start_mem && access) begin
			dbus_cyc <= 1'b1;
			dbus_we <= mem_store;
		end else if (ack_seen) begin
			dbus_cyc <= 1'b0;
			dbus_we <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_mem) begin
			dbus_adr <= alu_out;
			dbus_dat_w <= store_val;
		end
		if (ack_seen)
			load_q <= dbus_dat_r; // only read back when mem_load is set
	end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int data_width = 32;
	localparam int reg_addr_width = 3;
	localparam logic [data_width-1:0] reset_pc = 32'h0000_0000;

	typedef enum logic [1:0] {
		class_arith = 2'b00,
		class_branch = 2'b01,
		class_mem = 2'b10,
		class_misc = 2'b11
	} instr_class_t;

	// code 4'b1101 is reserved and gives zero
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_addc = 4'b0001,
		alu_sub = 4'b0010,
		alu_subc = 4'b0011,
		alu_lsl = 4'b0100,
		alu_lsr = 4'b0101,
		alu_and = 4'b0110,
		alu_xor = 4'b0111,
		alu_bic = 4'b1000,
		alu_bst = 4'b1001,
		alu_or = 4'b1010,
		alu_movhi = 4'b1011,
		alu_zero = 4'b1100,
		alu_asr = 4'b1110,
		alu_mov = 4'b1111
	} alu_op_t;

	typedef enum logic [2:0] {
		cond_never = 3'b000,
		cond_ne = 3'b001,
		cond_eq = 3'b010,
		cond_cc = 3'b011,
		cond_cs = 3'b100,
		cond_always = 3'b111
	} branch_cond_t;

	// arithmetic, memory and misc format
	// movhi takes its 16-bit immediate from {use_pc, imm16} and ignores use_pc
	typedef struct packed {
		instr_class_t instr_class;
		logic [3:0] opcode;
		logic [reg_addr_width-1:0] rd;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb;
		logic use_imm; // imm16 replaces rb as operand 2
		logic use_pc; // pc_plus_4 replaces ra as operand 1
		logic [14:0] imm16; // sign extended
	} arith_fmt_t;

	typedef struct packed {
		instr_class_t instr_class;
		branch_cond_t cond;
		logic is_call;
		logic via_reg; // target is ra instead of pc_plus_4 + imm16
		logic [reg_addr_width-1:0] rd; // link register for calls
		logic [reg_addr_width-1:0] ra;
		logic [1:0] pad;
		logic [16:0] imm16; // sign extended byte offset
	} branch_fmt_t;

	typedef union packed {
		arith_fmt_t arith;
		branch_fmt_t branch;
	} instr_word_t;

	localparam logic [3:0] mem_op_load = 4'h0;
	localparam logic [3:0] mem_op_store = 4'h1;
	localparam logic [3:0] misc_op_halt = 4'hf;

	// ------------------------------------------------------------------
	// sequencer phases
	// ------------------------------------------------------------------
	localparam int phase_width = 3;
	localparam logic [phase_width-1:0] ph_fetch = 3'd0;
	localparam logic [phase_width-1:0] ph_fetch_wait = 3'd1;
	localparam logic [phase_width-1:0] ph_decode = 3'd2;
	localparam logic [phase_width-1:0] ph_exec = 3'd3;
	localparam logic [phase_width-1:0] ph_mem = 3'd4;
	localparam logic [phase_width-1:0] ph_mem_wait = 3'd5;
	localparam logic [phase_width-1:0] ph_wb = 3'd6;
	localparam logic [phase_width-1:0] ph_halt = 3'd7;

endpackage

`default_nettype wire

// File: hw/cpu_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_regfile (
	input logic clk,
	input logic [cpu_pkg::reg_addr_width-1:0] ra_sel,
	input logic [cpu_pkg::reg_addr_width-1:0] rb_sel,
	input logic wr_en,
	input logic [cpu_pkg::reg_addr_width-1:0] wr_sel,
	input logic [cpu_pkg::data_width-1:0] wr_data,
	output logic [cpu_pkg::data_width-1:0] ra,
	output logic [cpu_pkg::data_width-1:0] rb
);

	logic [cpu_pkg::data_width-1:0] regs [1 << cpu_pkg::reg_addr_width];

	assign ra = regs[ra_sel];
	assign rb = regs[rb_sel];

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[wr_sel] <= wr_data; // r0 is an ordinary register
	end

endmodule

`default_nettype wire

// File: tb.f
hw/cpu_pkg.sv
hw/cpu_control.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_regfile.sv
hw/cpu_exec.sv
hw/cpu_mem.sv
hw/cpu_core.sv
tests/wb_ram_model.sv
tests/cpu_tb.sv

// File: tests/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	localparam int timeout_cycles = 100000;
	localparam int quiet_cycles = 50;
	localparam int prog_depth = 1024;
	localparam logic [31:0] data_base = 32'h0000_0100;

	logic clk;
	logic rst_n;
	logic ibus_cyc;
	logic ibus_stb;
	logic [31:0] ibus_adr;
	logic [31:0] ibus_dat_r;
	logic ibus_ack;
	logic dbus_cyc;
	logic dbus_stb;
	logic dbus_we;
	logic [31:0] dbus_adr;
	logic [31:0] dbus_dat_w;
	logic [31:0] dbus_dat_r;
	logic dbus_ack;
	logic halted;

	logic [31:0] prog [prog_depth];
	int n_prog;
	int store_off;
	logic [31:0] rand_state;
	logic [31:0] m_reg [8];
	logic m_z;
	logic m_c;
	logic [31:0] m_mem [1024];
	logic [64:0] exp_dbus [$]; // {we, adr, dat_w}
	logic [31:0] exp_fetch [$];
	int value_errors;
	int other_errors;

	cpu_core UUT (
		.clk(clk), .rst_n(rst_n), .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb),
		.ibus_adr(ibus_adr), .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
		.dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we), .dbus_adr(dbus_adr),
		.dbus_dat_w(dbus_dat_w), .dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
		.halted(halted)
	);

	wb_ram_model #(.seed(32'h6f67716e)) imem (
		.clk(clk), .rst_n(rst_n), .cyc(ibus_cyc), .stb(ibus_stb), .we(1'b0),
		.adr(ibus_adr), .dat_w(32'h0), .dat_r(ibus_dat_r), .ack(ibus_ack)
	);

	wb_ram_model #(.seed(32'h6f67716e)) dmem (
		.clk(clk), .rst_n(rst_n), .cyc(dbus_cyc), .stb(dbus_stb), .we(dbus_we),
		.adr(dbus_adr), .dat_w(dbus_dat_w), .dat_r(dbus_dat_r), .ack(dbus_ack)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// ----------------------------------------------------------------------
	// program builder
	// ----------------------------------------------------------------------
	function automatic logic [31:0] arith_word(input cpu_pkg::instr_class_t cls,
		input logic [3:0] op, input logic [2:0] rd, input logic [2:0] ra, input logic [2:0] rb,
		input logic use_imm, input logic use_pc, input logic [14:0] imm);
		cpu_pkg::instr_word_t w;
		w.arith.instr_class = cls;
		w.arith.opcode = op;
		w.arith.rd = rd;
		w.arith.ra = ra;
		w.arith.rb = rb;
		w.arith.use_imm = use_imm;
		w.arith.use_pc = use_pc;
		w.arith.imm16 = imm;
		return w;
	endfunction

	function automatic logic [31:0] branch_word(input logic [2:0] cond, input logic is_call,
		input logic via_reg, input logic [2:0] rd, input logic [2:0] ra, input logic [16:0] imm);
		cpu_pkg::instr_word_t w;
		w.branch.instr_class = cpu_pkg::class_branch;
		w.branch.cond = cpu_pkg::branch_cond_t'(cond);
		w.branch.is_call = is_call;
		w.branch.via_reg = via_reg;
		w.branch.rd = rd;
		w.branch.ra = ra;
		w.branch.pad = 2'b00;
		w.branch.imm16 = imm;
		return w;
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[n_prog] = w;
		n_prog++;
	endtask

	task automatic load_const(input logic [2:0] rd, input logic [31:0] v);
		emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_movhi, rd, 3'd0, 3'd0, 1'b1,
			v[31], v[30:16]));
		emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_or, rd, rd, 3'd0, 1'b1, 1'b0,
			{1'b0, v[13:0]}));
		if (v[14])
			emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_bst, rd, rd, 3'd0, 1'b1, 1'b0, 15'd14));
		if (v[15])
			emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_bst, rd, rd, 3'd0, 1'b1, 1'b0, 15'd15));
	endtask

	task automatic store_next(input logic [2:0] rb);
		emit(arith_word(cpu_pkg::class_mem, cpu_pkg::mem_op_store, 3'd0, 3'd4, rb, 1'b0, 1'b0,
			15'(store_off)));
		store_off += 4; // stores go to consecutive words above r4
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		n_prog = 0;
		store_off = 0;
		for (int r = 0; r < 8; r++)
			emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_movhi, 3'(r), 3'd0, 3'd0, 1'b1,
				1'b0, 15'd0));
		load_const(3'd4, data_base);
		for (int op = 0; op < 16; op++) begin
			for (int imm = 0; imm < 2; imm++) begin
				load_const(3'd1, next_rand());
				load_const(3'd2, next_rand());
				// sets C from the top bit of r1 for addc and subc
				emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_add, 3'd7, 3'd1, 3'd1, 1'b0,
					1'b0, 15'd0));
				a = next_rand();
				emit(arith_word(cpu_pkg::class_arith, 4'(op), 3'd3, 3'd1, 3'd2, 1'(imm), 1'b0,
					a[14:0]));
				store_next(3'd3);
			end
		end
		emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_add, 3'd3, 3'd0, 3'd0, 1'b1, 1'b1,
			15'd12));
		store_next(3'd3);

		// ------------------------------------------------------------------
		// compares followed by every branch condition
		// ------------------------------------------------------------------
		for (int k = 0; k < 4; k++) begin
			a = next_rand();
			case (k)
				0: b = a;
				1: b = a ^ 32'h0000_0010;
				2: begin
					a = a >> 1;
					b = a | 32'h8000_0000; // a below b so sub borrows
				end
				default: begin
					b = {1'b0, a[30:0]};
					a = a | 32'h8000_0000;
				end
			endcase
			load_const(3'd1, a);
			load_const(3'd2, b);
			for (int c = 0; c < 8; c++) begin
				emit(arith_word(cpu_pkg::class_arith, cpu_pkg::alu_sub, 3'd7, 3'd1, 3'd2, 1'b0,
					1'b0, 15'd0));
				if (c % 2 == 1)
					store_next(3'd1); // flags must survive a memory instruction
				emit(branch_word(3'(c), 1'b0, 1'b0, 3'd0, 3'd0, 17'd4));
				store_next(3'd2); // marker store that a taken branch skips
			end
		end

		// call, link store, jump over the subroutine, then the subroutine itself
		emit(branch_word(3'(cpu_pkg::cond_always), 1'b1, 1'b0, 3'd5, 3'd0, 17'd8));
		store_next(3'd5);
		emit(branch_word(3'(cpu_pkg::cond_always), 1'b0, 1'b0, 3'd0, 3'd0, 17'd8));
		store_next(3'd1);
		emit(branch_word(3'(cpu_pkg::cond_always), 1'b0, 1'b1, 3'd0, 3'd5, 17'd0));

		for (int i = 0; i < 8; i++) begin
			emit(arith_word(cpu_pkg::class_mem, cpu_pkg::mem_op_load, 3'd3, 3'd4, 3'd0, 1'b0,
				1'b0, 15'(i * 8)));
			store_next(3'd3);
		end
		emit(arith_word(cpu_pkg::class_misc, cpu_pkg::misc_op_halt, 3'd0, 3'd0, 3'd0, 1'b0,
			1'b0, 15'd0));
	endtask

	// ----------------------------------------------------------------------
	// reference model that runs the program and records the expected bus traffic
	// ----------------------------------------------------------------------
	task automatic run_model();
		cpu_pkg::instr_word_t w;
		logic [31:0] pc;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] addr;
		logic [31:0] target;
		logic [32:0] wide;
		logic taken;
		int steps;
		pc = cpu_pkg::reset_pc;
		m_z = 1'b0;
		m_c = 1'b0;
		steps = 0;
		while (steps < timeout_cycles) begin
			steps++;
			w = prog[pc[11:2]];
			exp_fetch.push_back(pc);
			if (w.arith.instr_class == cpu_pkg::class_misc) begin
				if (w.arith.opcode == cpu_pkg::misc_op_halt)
					break;
				pc = pc + 32'd4;
			end else if (w.arith.instr_class == cpu_pkg::class_branch) begin
				case (w.branch.cond)
					cpu_pkg::cond_always: taken = 1'b1;
					cpu_pkg::cond_ne: taken = !m_z;
					cpu_pkg::cond_eq: taken = m_z;
					cpu_pkg::cond_cc: taken = !m_c;
					cpu_pkg::cond_cs: taken = m_c;
					default: taken = 1'b0;
				endcase
				target = w.branch.via_reg ? m_reg[w.branch.ra] :
					pc + 32'd4 + {{15{w.branch.imm16[16]}}, w.branch.imm16};
				if (w.branch.is_call)
					m_reg[w.branch.rd] = pc + 32'd4;
				pc = taken ? target : pc + 32'd4;
			end else if (w.arith.instr_class == cpu_pkg::class_mem) begin
				addr = m_reg[w.arith.ra] + {{17{w.arith.imm16[14]}}, w.arith.imm16};
				if (w.arith.opcode == cpu_pkg::mem_op_load) begin
					exp_dbus.push_back({1'b0, addr, 32'h0});
					m_reg[w.arith.rd] = m_mem[addr[11:2]];
				end else if (w.arith.opcode == cpu_pkg::mem_op_store) begin
					exp_dbus.push_back({1'b1, addr, m_reg[w.arith.rb]});
					m_mem[addr[11:2]] = m_reg[w.arith.rb];
				end
				pc = pc + 32'd4;
			end else begin
				op1 = w.arith.use_pc ? pc + 32'd4 : m_reg[w.arith.ra];
				op2 = w.arith.use_imm ? {{17{w.arith.imm16[14]}}, w.arith.imm16} :
					m_reg[w.arith.rb];
				if (w.arith.opcode == cpu_pkg::alu_movhi && w.arith.use_imm)
					op2 = {16'h0000, w.arith.use_pc, w.arith.imm16}; // 16-bit immediate
				case (w.arith.opcode)
					cpu_pkg::alu_add: wide = {1'b0, op1} + {1'b0, op2};
					cpu_pkg::alu_addc: wide = {1'b0, op1} + {1'b0, op2} + 33'(m_c);
					cpu_pkg::alu_sub: wide = {1'b0, op1} - {1'b0, op2};
					cpu_pkg::alu_subc: wide = {1'b0, op1} - {1'b0, op2} + 33'(m_c);
					cpu_pkg::alu_lsl: wide = {1'b0, op1} << op2[4:0];
					cpu_pkg::alu_lsr: wide = {1'b0, op1 >> op2[4:0]};
					cpu_pkg::alu_and: wide = {1'b0, op1 & op2};
					cpu_pkg::alu_xor: wide = {1'b0, op1 ^ op2};
					cpu_pkg::alu_bic: wide = {1'b0, op1 & ~(32'h1 << op2[4:0])};
					cpu_pkg::alu_bst: wide = {1'b0, op1 | (32'h1 << op2[4:0])};
					cpu_pkg::alu_or: wide = {1'b0, op1 | op2};
					cpu_pkg::alu_movhi: wide = {1'b0, w.arith.use_pc, w.arith.imm16, 16'h0000};
					cpu_pkg::alu_asr: wide = {1'b0, $unsigned($signed(op1) >>> op2[4:0])};
					cpu_pkg::alu_mov: wide = {1'b0, op1};
					default: wide = '0; // zero and the reserved code
				endcase
				m_z = op1 == op2;
				m_c = wide[32];
				m_reg[w.arith.rd] = wide[31:0];
				pc = pc + 32'd4;
			end
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		value_errors++;
		$display("FAILED %s: got %h, expected %h", name, got, want);
	endtask

	// ----------------------------------------------------------------------
	// bus checks sampled mid cycle
	// ----------------------------------------------------------------------
	always @(negedge clk) begin : bus_checks
		logic [64:0] want;
		logic [31:0] want_pc;
		if (rst_n) begin
			// classic single transfers keep stb together with cyc
			assert (ibus_stb == ibus_cyc) else report_value("ibus_stb", 32'(ibus_stb),
				32'(ibus_cyc));
			assert (dbus_stb == dbus_cyc) else report_value("dbus_stb", 32'(dbus_stb),
				32'(dbus_cyc));
			if (dbus_cyc && dbus_ack) begin
				if (exp_dbus.size() == 0) begin
					other_errors++;
					$display("data bus access at %h that the model does not expect", dbus_adr);
				end else begin
					want = exp_dbus.pop_front();
					assert (dbus_we == want[64]) else report_value("dbus_we", 32'(dbus_we),
						32'(want[64]));
					assert (dbus_adr == want[63:32]) else report_value("dbus_adr", dbus_adr,
						want[63:32]);
					assert (!want[64] || dbus_dat_w == want[31:0]) else
						report_value("dbus_dat_w", dbus_dat_w, want[31:0]);
				end
			end
			if (ibus_cyc && ibus_ack) begin
				if (exp_fetch.size() == 0) begin
					other_errors++;
					$display("instruction fetch at %h past the end of the program", ibus_adr);
				end else begin
					want_pc = exp_fetch.pop_front();
					assert (ibus_adr == want_pc) else report_value("ibus_adr", ibus_adr, want_pc);
				end
			end
			assert (!(halted && ibus_cyc)) else begin
				other_errors++;
				$display("instruction bus cycle started after halt");
			end
		end
	end

	initial begin
		int cycles;
		rst_n = 1'b0;
		value_errors = 0;
		other_errors = 0;
		rand_state = 32'h6f67716e;
		build_program();
		run_model();
		#1;
		for (int i = 0; i < n_prog; i++)
			imem.mem[i] = prog[i];
		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (!ibus_cyc) else report_value("ibus_cyc", 32'(ibus_cyc), 32'h0);
		assert (!ibus_stb) else report_value("ibus_stb", 32'(ibus_stb), 32'h0);
		assert (!dbus_cyc) else report_value("dbus_cyc", 32'(dbus_cyc), 32'h0);
		assert (!dbus_stb) else report_value("dbus_stb", 32'(dbus_stb), 32'h0);
		assert (!dbus_we) else report_value("dbus_we", 32'(dbus_we), 32'h0);
		assert (!halted) else report_value("halted", 32'(halted), 32'h0);
		rst_n = 1'b1;

		cycles = 0;
		while (!halted && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			other_errors++;
			$display("core never halted within %0d cycles", timeout_cycles);
		end else begin
			cycles = 0;
			while (cycles < quiet_cycles) begin
				@(negedge clk);
				assert (halted) else report_value("halted", 32'(halted), 32'h1);
				cycles++;
			end
			if (exp_dbus.size() != 0) begin
				other_errors++;
				$display("%0d expected data bus accesses never happened", exp_dbus.size());
			end
			if (exp_fetch.size() != 0) begin
				other_errors++;
				$display("%0d expected instruction fetches never happened", exp_fetch.size());
			end
		end
		$display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/wb_ram_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_ram_model #(
	parameter int depth_log2 = 10,
	parameter logic [31:0] seed = 32'h6f67716e,
	parameter int max_wait = 3
) (
	input logic clk,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [31:0] adr,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack
);

	logic [31:0] mem [1 << depth_log2];
	logic [31:0] rng;
	int wait_left;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		rng = seed;
		wait_left = 0;
		for (int i = 0; i < (1 << depth_log2); i++)
			mem[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0193); // every address bit shows up in the word
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			dat_r <= '0;
		end else if (ack) begin
			ack <= 1'b0; // one cycle ack, master drops cyc now
		end else if (cyc && stb) begin
			if (wait_left == 0) begin
				ack <= 1'b1;
				if (we)
					mem[adr[depth_log2+1:2]] = dat_w;
				else
					dat_r <= mem[adr[depth_log2+1:2]];
				rng = lcg_step(rng);
				wait_left <= int'(rng[18:16]) % (max_wait + 1); // wait states for the next access
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

endmodule

`default_nettype wire
